// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instructions per fetch group
`define FETCH_W 4

// PC and instruction width, PC counts 16-bit words
`define PC_W 16

// Predictor table index width (16 counters)
`define BHT_IDX_W 4

// Row address width of each memory bank
// Four banks of 64 rows give 256 words
`define IMEM_ROWS_W 6

`endif

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	`include "fetch_defines.svh"

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [3:0] OP_BRANCH = 4'b1100;
	localparam logic [3:0] OP_JUMP = 4'b1101;

	////////////////////////////////////////////////////////////////////////////
	// Instruction formats
	////////////////////////////////////////////////////////////////////////////

	// Conditional branch, offset relative to the branch PC
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] cond;
		logic signed [`PC_W-9:0] off;
	} br_fmt_t;

	// Immediate jump, always taken
	typedef struct packed {
		logic [3:0] op;
		logic signed [`PC_W-5:0] off;
	} jmp_fmt_t;

	// One instruction word, opcode shares the top nibble in both views
	typedef union packed {
		br_fmt_t br;
		jmp_fmt_t jmp;
	} instr_u;

endpackage

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	`include "fetch_defines.svh"

	// Slot 0 sits in the top element of each group array
	// Mask bit FETCH_W-1 is slot 0 as well

	typedef struct packed {
		logic valid;
		logic [`PC_W-1:0] pc;
		logic [`FETCH_W-1:0][`PC_W-1:0] inst;
	} fetch_grp_t;

	// Predecode result for one group
	typedef struct packed {
		logic [`FETCH_W-1:0] sel;
		logic [`FETCH_W-1:0] jmp;
		logic [`PC_W-1:0] tgt0;
		logic [`PC_W-1:0] tgt1;
		logic [`PC_W-1:0] jtgt;
		logic [`PC_W-1:0] bpc0;
		logic [`PC_W-1:0] bpc1;
	} scan_t;

	// Bundle handed to decode
	typedef struct packed {
		logic [`FETCH_W-1:0][`PC_W-1:0] pc_to_dec;
		logic [`FETCH_W-1:0][`PC_W-1:0] inst_to_dec;
		logic [`FETCH_W-1:0][`PC_W-1:0] recv_pc_to_dec;
		logic [`FETCH_W-1:0] pred_result_to_dec;
	} dec_bundle_t;

	typedef struct packed {
		logic valid;
		logic [`PC_W-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== hw/pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module pc_gen
	import fetch_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_en,
	input wire redirect_t redirect,
	output logic [`PC_W-1:0] pc,
	output logic issue_valid
);

	localparam int LG = $clog2(`FETCH_W);

	////////////////////////////////////////////////////////////////////////////
	// F1 fetch PC
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= '0;
		end
		else if (redirect.valid)
		begin
			pc <= redirect.target;
		end
		else if (fetch_en)
		begin
			// Step one full group
			pc <= pc + `PC_W'(`FETCH_W);
		end
	end

	// Group read this cycle is on the wrong path when a redirect is out
	assign issue_valid = fetch_en && !redirect.valid;

	// Offset within a group only moves when a redirect target is loaded
	a_pc_offset: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(redirect.valid) |-> pc[LG-1:0] == $past(pc[LG-1:0]))
		else $error("pc_gen: PC left group alignment without a redirect");

endmodule

`default_nettype wire

// ==== hw/inst_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module inst_mem
	import fetch_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic we,
	input wire logic [`PC_W-1:0] waddr,
	input wire logic [`PC_W-1:0] wdata,
	input wire logic [`PC_W-1:0] pc,
	input wire logic issue_valid,
	output fetch_grp_t grp
);

	localparam int LG = $clog2(`FETCH_W);
	localparam int ROWS = 1 << `IMEM_ROWS_W;

	logic [`FETCH_W-1:0][`PC_W-1:0] bank_word;
	logic [`FETCH_W-1:0][`PC_W-1:0] inst_d;
	logic [`FETCH_W-1:0][`PC_W-1:0] inst_q;
	logic [`PC_W-1:0] pc_q;
	logic vld_q;

	// Bank b holds every word whose low address bits equal b
	for (genvar b = 0; b < `FETCH_W; b++)
	begin : g_bank
		logic [`PC_W-1:0] mem [ROWS];
		logic [LG-1:0] slot;
		logic [`PC_W-1:0] addr;

		// Which slot of the group lands in this bank
		assign slot = LG'(b) - pc[LG-1:0];
		assign addr = pc + `PC_W'(slot);

		always_ff @(posedge clk)
		begin
			if (we && waddr[LG-1:0] == LG'(b))
			begin
				mem[waddr[`IMEM_ROWS_W+LG-1:LG]] <= wdata;
			end
		end

		assign bank_word[b] = mem[addr[`IMEM_ROWS_W+LG-1:LG]];
	end

	// Rotate bank outputs back into slot order
	always_comb
	begin
		for (int s = 0; s < `FETCH_W; s++)
		begin
			inst_d[`FETCH_W-1-s] = bank_word[LG'(pc[LG-1:0] + LG'(s))];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vld_q <= 1'b0;
		else
			vld_q <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		pc_q <= pc;
		inst_q <= inst_d;
	end

	assign grp.valid = vld_q;
	assign grp.pc = pc_q;
	assign grp.inst = inst_q;

endmodule

`default_nettype wire

// ==== hw/branch_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module branch_scan
	import isa_pkg::*;
	import fetch_pkg::*;
(
	input wire fetch_grp_t grp,
	output scan_t scan
);

	logic [`FETCH_W-1:0] is_br;

	////////////////////////////////////////////////////////////////////////////
	// F2 predecode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin : scan_slots
		instr_u w;
		logic [`PC_W-1:0] spc;
		logic [1:0] nbr;
		logic jfound;
		int b;

		scan = '0;
		is_br = '0;
		nbr = 2'd0;
		jfound = 1'b0;

		for (int s = 0; s < `FETCH_W; s++)
		begin
			b = `FETCH_W - 1 - s;
			w = grp.inst[b];
			spc = grp.pc + `PC_W'(s);

			if (w.br.op == OP_BRANCH)
			begin
				is_br[b] = 1'b1;
				// Only the first two branches get a predictor port
				if (nbr == 2'd0)
				begin
					scan.sel[b] = 1'b1;
					scan.bpc0 = spc;
					scan.tgt0 = spc + {{8{w.br.off[7]}}, w.br.off};
					nbr = 2'd1;
				end
				else if (nbr == 2'd1)
				begin
					scan.sel[b] = 1'b1;
					scan.bpc1 = spc;
					scan.tgt1 = spc + {{8{w.br.off[7]}}, w.br.off};
					nbr = 2'd2;
				end
			end

			if (w.jmp.op == OP_JUMP)
			begin
				scan.jmp[b] = 1'b1;
				if (!jfound)
				begin
					scan.jtgt = spc + {{4{w.jmp.off[11]}}, w.jmp.off};
					jfound = 1'b1;
				end
			end
		end
	end

	// Select mask picks real branches only, never more than two
	always_comb
	begin
		a_sel_mask: assert final ($countones(scan.sel) <= 2 && (scan.sel & ~is_br) == '0)
			else $error("branch_scan: bad select mask %b", scan.sel);
	end

endmodule

`default_nettype wire

// ==== hw/branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module branch_predictor
	import fetch_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire scan_t scan,
	output logic [1:0] pred,
	input wire logic upd_valid,
	input wire logic [`PC_W-1:0] upd_pc,
	input wire logic upd_taken
);

	localparam int ENTRIES = 1 << `BHT_IDX_W;

	logic [1:0] bht [ENTRIES];
	logic [`BHT_IDX_W-1:0] idx0;
	logic [`BHT_IDX_W-1:0] idx1;
	logic [`BHT_IDX_W-1:0] uidx;
	logic two_sel;

	assign idx0 = scan.bpc0[`BHT_IDX_W-1:0];
	assign idx1 = scan.bpc1[`BHT_IDX_W-1:0];
	assign uidx = upd_pc[`BHT_IDX_W-1:0];

	// More than one bit set in the select mask
	assign two_sel = |(scan.sel & (scan.sel - 1'b1));

	// High counter bit is the taken guess
	assign pred[1] = (|scan.sel) && bht[idx0][1];
	assign pred[0] = two_sel && bht[idx1][1];

	////////////////////////////////////////////////////////////////////////////
	// Training, saturating two-bit counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// Weakly not taken
			for (int i = 0; i < ENTRIES; i++)
			begin
				bht[i] <= 2'b01;
			end
		end
		else if (upd_valid)
		begin
			if (upd_taken)
			begin
				if (bht[uidx] != 2'b11)
					bht[uidx] <= bht[uidx] + 2'd1;
			end
			else
			begin
				if (bht[uidx] != 2'b00)
					bht[uidx] <= bht[uidx] - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/dataout_pack.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module dataout_pack
	import fetch_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire fetch_grp_t grp,
	input wire scan_t scan,
	input wire logic [1:0] pred,
	output redirect_t redirect,
	output dec_bundle_t bundle,
	output logic out_valid
);

	dec_bundle_t bundle_d;
	logic redir_hit;
	logic [`PC_W-1:0] redir_tgt;

	////////////////////////////////////////////////////////////////////////////
	// Recovery PCs, prediction bits and nop masking
	////////////////////////////////////////////////////////////////////////////

	// Walks slots in program order so any one- or two-branch select
	// pattern falls out of the same loop
	always_comb
	begin : pack
		logic [`PC_W-1:0] spc;
		logic [`PC_W-1:0] btgt;
		logic taken;
		logic nbr;
		int b;

		bundle_d = '0;
		bundle_d.inst_to_dec = grp.inst;
		redir_hit = 1'b0;
		redir_tgt = '0;
		nbr = 1'b0;
		btgt = '0;
		taken = 1'b0;

		for (int s = 0; s < `FETCH_W; s++)
		begin
			b = `FETCH_W - 1 - s;
			spc = grp.pc + `PC_W'(s);
			bundle_d.pc_to_dec[b] = spc;

			if (redir_hit)
			begin
				// Wrong path behind the redirect
				bundle_d.inst_to_dec[b] = '0;
			end
			else if (scan.sel[b])
			begin
				// First selected branch uses pred[1], second pred[0]
				taken = nbr ? pred[0] : pred[1];
				btgt = nbr ? scan.tgt1 : scan.tgt0;
				nbr = 1'b1;
				bundle_d.pred_result_to_dec[b] = taken;
				// Recover to the path not predicted
				bundle_d.recv_pc_to_dec[b] = taken ? spc + `PC_W'(1) : btgt;
				if (taken)
				begin
					redir_hit = 1'b1;
					redir_tgt = btgt;
				end
			end
			else if (scan.jmp[b])
			begin
				bundle_d.inst_to_dec[b] = '0;
				redir_hit = 1'b1;
				redir_tgt = scan.jtgt;
			end
		end
	end

	assign redirect.valid = grp.valid && redir_hit;
	assign redirect.target = redir_tgt;

	////////////////////////////////////////////////////////////////////////////
	// F3 output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= grp.valid;
	end

	always_ff @(posedge clk)
	begin
		bundle <= bundle_d;
	end

	// Redirect comes from a live group and leaves a one-group bubble behind it
	a_redirect_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		redirect.valid |-> grp.valid ##1 !grp.valid)
		else $error("dataout_pack: redirect without a live group or missing bubble");

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top
	import fetch_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_en,
	input wire logic imem_we,
	input wire logic [`PC_W-1:0] imem_addr,
	input wire logic [`PC_W-1:0] imem_wdata,
	input wire logic upd_valid,
	input wire logic [`PC_W-1:0] upd_pc,
	input wire logic upd_taken,
	output logic out_valid,
	output dec_bundle_t bundle
);

	logic [`PC_W-1:0] pc;
	logic issue_valid;
	fetch_grp_t grp;
	scan_t scan;
	logic [1:0] pred;
	redirect_t redirect;

	// F1
	pc_gen u_pc_gen (
		.clk (clk),
		.rst_n (rst_n),
		.fetch_en (fetch_en),
		.redirect (redirect),
		.pc (pc),
		.issue_valid (issue_valid)
	);

	// F1 to F2 boundary is the registered group read
	inst_mem u_inst_mem (
		.clk (clk),
		.rst_n (rst_n),
		.we (imem_we),
		.waddr (imem_addr),
		.wdata (imem_wdata),
		.pc (pc),
		.issue_valid (issue_valid),
		.grp (grp)
	);

	// F2
	branch_scan u_branch_scan (
		.grp (grp),
		.scan (scan)
	);

	branch_predictor u_branch_predictor (
		.clk (clk),
		.rst_n (rst_n),
		.scan (scan),
		.pred (pred),
		.upd_valid (upd_valid),
		.upd_pc (upd_pc),
		.upd_taken (upd_taken)
	);

	// F3
	dataout_pack u_dataout_pack (
		.clk (clk),
		.rst_n (rst_n),
		.grp (grp),
		.scan (scan),
		.pred (pred),
		.redirect (redirect),
		.bundle (bundle),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb
	import isa_pkg::*;
	import fetch_pkg::*;
();

	localparam int MEM_WORDS = (1 << `IMEM_ROWS_W) * `FETCH_W;
	localparam int MAX_REC = 64;
	localparam int TIMEOUT = 50;

	logic clk;
	logic rst_n;
	logic fetch_en;
	logic imem_we;
	logic [`PC_W-1:0] imem_addr;
	logic [`PC_W-1:0] imem_wdata;
	logic upd_valid;
	logic [`PC_W-1:0] upd_pc;
	logic upd_taken;
	logic out_valid;
	dec_bundle_t bundle;

	// Shadow of the instruction memory
	logic [`PC_W-1:0] mem_img [MEM_WORDS];
	bit named [MEM_WORDS];

	// Predictor training list
	logic [`PC_W-1:0] trn_pc [MAX_REC];
	logic trn_taken [MAX_REC];
	int n_trn;

	// Expected bundles, slot 0 is the top bit of pred and nop
	logic [`PC_W-1:0] exp_base [MAX_REC];
	logic [`FETCH_W-1:0] exp_pred [MAX_REC];
	logic [`FETCH_W-1:0] exp_nop [MAX_REC];
	logic [`PC_W-1:0] exp_recv [MAX_REC][`FETCH_W];
	int n_exp;

	int err_cnt;
	integer seed;

	always #2 clk = ~clk;

	fetch_top u_fetch_top (
		.clk (clk),
		.rst_n (rst_n),
		.fetch_en (fetch_en),
		.imem_we (imem_we),
		.imem_addr (imem_addr),
		.imem_wdata (imem_wdata),
		.upd_valid (upd_valid),
		.upd_pc (upd_pc),
		.upd_taken (upd_taken),
		.out_valid (out_valid),
		.bundle (bundle)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			err_cnt++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Case file and setup
	////////////////////////////////////////////////////////////////////////////

	task automatic read_cases();
		integer fd;
		int rc;
		int n_br;
		int n_jmp;
		logic [8*8-1:0] tag;
		logic [8*128-1:0] line;
		logic [`PC_W-1:0] addr;
		logic [`PC_W-1:0] word;
		logic taken;
		logic [`FETCH_W-1:0] pred;
		logic [`FETCH_W-1:0] nop;
		logic [`PC_W-1:0] r0;
		logic [`PC_W-1:0] r1;
		logic [`PC_W-1:0] r2;
		logic [`PC_W-1:0] r3;
		instr_u w;

		n_br = 0;
		n_jmp = 0;
		fd = $fopen("dv/fetch_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open the case file dv/fetch_cases.txt");
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag == "#")
			begin
				rc = $fgets(line, fd);
			end
			else if (tag == "M")
			begin
				rc = $fscanf(fd, "%h %h", addr, word);
				if (rc != 2)
					abort_run("memory record in the case file is malformed");
				w = word;
				if (w.br.op == OP_BRANCH)
					n_br++;
				else if (w.jmp.op == OP_JUMP)
					n_jmp++;
				mem_img[addr % MEM_WORDS] = word;
				named[addr % MEM_WORDS] = 1'b1;
			end
			else if (tag == "U")
			begin
				rc = $fscanf(fd, "%h %h", addr, taken);
				if (rc != 2 || n_trn >= MAX_REC)
					abort_run("training record in the case file is malformed");
				trn_pc[n_trn] = addr;
				trn_taken[n_trn] = taken;
				n_trn++;
			end
			else if (tag == "B")
			begin
				rc = $fscanf(fd, "%h %b %b %h %h %h %h", addr, pred, nop, r0, r1, r2, r3);
				if (rc != 7 || n_exp >= MAX_REC)
					abort_run("bundle record in the case file is malformed");
				exp_base[n_exp] = addr;
				exp_pred[n_exp] = pred;
				exp_nop[n_exp] = nop;
				exp_recv[n_exp][0] = r0;
				exp_recv[n_exp][1] = r1;
				exp_recv[n_exp][2] = r2;
				exp_recv[n_exp][3] = r3;
				n_exp++;
			end
			else
			begin
				abort_run("unknown record type in the case file");
			end
		end
		$fclose(fd);
		if (n_exp == 0)
			abort_run("the case file holds no expected bundles");
		$display("Cases: %0d branches, %0d jumps, %0d updates, %0d bundles",
			n_br, n_jmp, n_trn, n_exp);
	endtask

	// Filler words keep opcode 0000 so they never scan as control
	task automatic fill_unused();
		instr_u w;
		logic [31:0] rnd;

		for (int a = 0; a < MEM_WORDS; a++)
		begin
			if (!named[a])
			begin
				rnd = $random(seed);
				w.jmp.op = 4'h0;
				w.jmp.off = rnd[`PC_W-5:0];
				mem_img[a] = w;
			end
		end
	endtask

	task automatic load_memory();
		for (int a = 0; a < MEM_WORDS; a++)
		begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= `PC_W'(a);
			imem_wdata <= mem_img[a];
			@(negedge clk);
			check_val("out_valid before fetch", 0, out_valid);
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	task automatic train_predictor();
		for (int i = 0; i < n_trn; i++)
		begin
			@(posedge clk);
			upd_valid <= 1'b1;
			upd_pc <= trn_pc[i];
			upd_taken <= trn_taken[i];
		end
		@(posedge clk);
		upd_valid <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bundle checking
	////////////////////////////////////////////////////////////////////////////

	// Returns the number of falling edges seen, the last one with out_valid high
	task automatic wait_bundle(input int k, output int cycles);
		bit got;

		got = 1'b0;
		cycles = 0;
		while (!got && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			got = out_valid;
		end
		if (!got)
			abort_run($sformatf("bundle %0d never arrived within %0d cycles", k, TIMEOUT));
	endtask

	task automatic check_bundle(input int k);
		int idx;
		logic [`PC_W-1:0] spc;
		logic [`PC_W-1:0] exp_inst;

		for (int s = 0; s < `FETCH_W; s++)
		begin
			idx = `FETCH_W - 1 - s;
			spc = exp_base[k] + `PC_W'(s);
			// Nop slots carry a zero word
			exp_inst = exp_nop[k][idx] ? '0 : mem_img[spc % MEM_WORDS];
			check_val($sformatf("bundle %0d slot %0d pc", k, s), spc,
				bundle.pc_to_dec[idx]);
			check_val($sformatf("bundle %0d slot %0d inst", k, s), exp_inst,
				bundle.inst_to_dec[idx]);
			check_val($sformatf("bundle %0d slot %0d recv_pc", k, s), exp_recv[k][s],
				bundle.recv_pc_to_dec[idx]);
		end
		check_val($sformatf("bundle %0d pred_result", k), exp_pred[k],
			bundle.pred_result_to_dec);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : main
		int cycles;

		clk = 1'b0;
		rst_n = 1'b0;
		fetch_en = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		upd_valid = 1'b0;
		upd_pc = '0;
		upd_taken = 1'b0;
		seed = 84;
		err_cnt = 0;
		n_trn = 0;
		n_exp = 0;

		read_cases();
		fill_unused();

		// Two clock edges in reset
		@(posedge clk);
		@(negedge clk);
		check_val("out_valid during reset", 0, out_valid);
		@(posedge clk);
		rst_n <= 1'b1;

		load_memory();
		train_predictor();

		@(posedge clk);
		fetch_en <= 1'b1;

		for (int k = 0; k < n_exp; k++)
		begin
			wait_bundle(k, cycles);
			// First falling edge lies inside the issue cycle
			if (k == 0)
				check_val("first bundle latency", 2, cycles - 1);
			check_bundle(k);
		end

		if (err_cnt == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("CHECKS FAILED");
			$fatal(1, "mismatches found");
		end
	end

endmodule

`default_nettype wire

// ==== fetch_subsys.f ====
+incdir+include
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/inst_mem.sv
hw/branch_scan.sv
hw/branch_predictor.sv
hw/dataout_pack.sv
hw/fetch_top.sv
dv/fetch_tb.sv

// ==== dv/fetch_cases.txt ====
# M <word address hex> <instruction hex>, U <branch pc hex> <taken 0/1>
# B <base pc hex> <pred bits slot0..3> <nop bits slot0..3> <recovery pc hex, slot 0 to 3>
M 0005 C020
M 0009 C017
M 0020 C010
M 0021 C008
M 0022 C004
M 0024 C0F0
M 0026 C003
M 0028 C001
M 002B C005
M 0031 C0E0
M 0032 C002
M 0035 C010
M 0037 C020
M 003A C006
M 003B C009
M 0045 D03B
U 0009 1
U 0009 1
U 002B 1
U 002B 1
U 0032 1
U 0032 1
U 0006 1
U 0006 0
# Sequential, lone branch, then a trained branch redirecting to 0020
B 0000 0000 0000 0000 0000 0000 0000
B 0004 0000 0000 0000 0025 0000 0000
B 0008 0100 0011 0000 000A 0000 0000
# Two-branch select patterns 1100 1010 1001 0110 0101 0011
B 0020 0000 0000 0030 0029 0000 0000
B 0024 0000 0000 0014 0000 0029 0000
B 0028 0001 0000 0029 0000 0000 002C
B 0030 0010 0001 0000 0011 0033 0000
B 0034 0000 0000 0000 0045 0000 0057
B 0038 0001 0000 0000 0000 0040 003C
# Immediate jump to 0080
B 0044 0000 0111 0000 0000 0000 0000
B 0080 0000 0000 0000 0000 0000 0000
